// ==== all.f ====
src/nocPkg.sv
src/flitDecoder.sv
src/packetTimer.sv
src/outputArbiter.sv
src/switchStage.sv
src/outputChannel.sv
sim/outputChannel_sva.sv
sim/outputChannelTb.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert --top-module outputChannelTb \
  -f all.f -Mdir obj_dir -o simv \
  && ./obj_dir/simv \
  || exit 1

// ==== sim/outputChannelTb.sv ====
`timescale 1ns/1ns

module outputChannelTb
  import nocPkg::*;
();

  localparam int numScenarios = 13;
  localparam int waitLimit    = 10;
  localparam logic [2:0] bodyId = 3'd2;

  typedef struct packed
  {
    portVecT                   req;
    logic [numPorts-1:0][11:0] lens; // Header length per port.
    logic [7:0]                hold; // Cycles the entry is applied.
  } scenarioT;

  logic    clk;
  logic    rst;
  flitT    inFlit [numPorts];
  portVecT inReq;
  outFlitT outFlit;

  scenarioT scenarios [numScenarios];

  // Values currently held on the DUT inputs.
  portVecT heldReq;
  flitT    heldFlit [numPorts];

  // Reference model state.
  flitT        mDecFlit [numPorts];
  portVecT     mDecReq;
  portVecT     mDecHeader;
  int          mState; // Granted port, or -1 when idle.
  logic [11:0] mTimeout [numPorts];
  logic [11:0] mCount [numPorts];
  outFlitT     mOut;

  outputChannel #(
    .TimerWidth(12)
  ) UUT (
    .clk    (clk),
    .rst    (rst),
    .inFlit (inFlit),
    .inReq  (inReq),
    .outFlit(outFlit)
  );

  always #5 clk = ~clk;

  function automatic scenarioT makeScenario(portVecT req, int l0, int l1, int l2, int l3,
                                            int l4, int hold);
    scenarioT s;
    s.req     = req;
    s.lens[0] = 12'(l0);
    s.lens[1] = 12'(l1);
    s.lens[2] = 12'(l2);
    s.lens[3] = 12'(l3);
    s.lens[4] = 12'(l4);
    s.hold    = 8'(hold);
    return s;
  endfunction

  // First requesting port after last in cyclic order, -1 when none.
  function automatic int nextRequester(portVecT reqs, int last, int span);
    int idx;
    for (int k = 1; k <= span; k++)
    begin
      idx = (last + k) % numPorts;
      if (reqs[idx])
        return idx;
    end
    return -1;
  endfunction

  task automatic resetModel();
    for (int p = 0; p < numPorts; p++)
    begin
      mDecFlit[p] = '0;
      mTimeout[p] = '0;
      mCount[p]   = '0;
    end
    mDecReq    = '0;
    mDecHeader = '0;
    mState     = -1;
    mOut       = '0;
  endtask

  // One rising edge of the pipeline, using the inputs held before the edge.
  task automatic modelEdge();
    portVecT timesUp;
    portVecT run;
    int      nextState;
    outFlitT nextOut;
    run = '0;
    for (int p = 0; p < numPorts; p++)
    begin
      timesUp[p] = (mCount[p] == mTimeout[p]);
    end
    if (mState < 0)
      nextState = nextRequester(mDecReq, numPorts - 1, numPorts);
    else if (mDecReq[mState] && !timesUp[mState])
    begin
      nextState    = mState;
      run[mState]  = 1'b1;
    end
    else
      nextState = nextRequester(mDecReq, mState, numPorts); // Holder comes last.
    nextOut = '0;
    if (mState >= 0)
    begin
      nextOut.valid = 1'b1;
      nextOut.src   = portIdxT'(mState);
      nextOut.flit  = mDecFlit[mState];
    end
    for (int p = 0; p < numPorts; p++)
    begin
      if (mDecHeader[p])
        mTimeout[p] = mDecFlit[p].length;
      mCount[p]   = run[p] ? mCount[p] + 12'd1 : 12'd0;
      mDecHeader[p] = heldReq[p] && (heldFlit[p].flitId == headerId);
      mDecFlit[p]   = heldFlit[p];
    end
    mDecReq = heldReq;
    mState  = nextState;
    mOut    = nextOut;
  endtask

  task automatic checkOutFlit(input outFlitT actual, input outFlitT expected);
    if (actual !== expected)
    begin
      $display("FAILED outFlit: got 0x%h, expected 0x%h", actual, expected);
      $display("TESTS FAILED");
      $fatal(1, "output flit mismatch");
    end
  endtask

  task automatic checkValid(input logic actual, input logic expected);
    if (actual !== expected)
    begin
      $display("FAILED outFlit.valid: got 0x%h, expected 0x%h", actual, expected);
      $display("TESTS FAILED");
      $fatal(1, "valid mismatch");
    end
  endtask

  // Drives one cycle of flits and checks the output at the falling edge.
  task automatic advanceCycle(input portVecT req, input logic [numPorts-1:0][11:0] lens,
                              input logic sendHeader);
    flitT f;
    @(posedge clk);
    modelEdge();
    for (int p = 0; p < numPorts; p++)
    begin
      f.flitId    = sendHeader ? headerId : bodyId;
      f.length    = sendHeader ? lens[p] : 12'($urandom);
      f.data      = 16'($urandom);
      heldFlit[p] = f;
      inFlit[p]  <= f;
    end
    heldReq = req;
    inReq  <= req;
    @(negedge clk);
    if (mOut.valid)
      checkOutFlit(outFlit, mOut);
    else
      checkValid(outFlit.valid, 1'b0);
  endtask

  task automatic runScenario(input int idx);
    scenarioT s;
    int       cycles;
    int       waited;
    s = scenarios[idx];
    advanceCycle(s.req, s.lens, 1'b1); // Header flits on every port.
    cycles = 1;
    if (s.req != '0 && !outFlit.valid)
    begin
      waited = 0;
      while (!outFlit.valid)
      begin
        if (waited >= waitLimit)
        begin
          $display("no output flit arrived in scenario %0d", idx);
          $display("TESTS FAILED");
          $fatal(1, "timeout");
        end
        advanceCycle(s.req, s.lens, 1'b0);
        waited++;
        cycles++;
      end
    end
    while (cycles < int'(s.hold))
    begin
      advanceCycle(s.req, s.lens, 1'b0);
      cycles++;
    end
  endtask

  initial
  begin
    void'($urandom(30));
    clk   = 1'b0;
    rst  <= 1'b1;
    inReq <= '0;
    for (int p = 0; p < numPorts; p++)
    begin
      inFlit[p]  <= '0;
      heldFlit[p] = '0;
    end
    heldReq = '0;

    scenarios[0]  = makeScenario(5'b00000, 0, 0, 0, 0, 0, 6);   // Idle after reset.
    scenarios[1]  = makeScenario(5'b11010, 2, 2, 2, 2, 2, 14);  // North wins from idle.
    scenarios[2]  = makeScenario(5'b11111, 1, 2, 3, 2, 1, 40);  // Full rotation.
    scenarios[3]  = makeScenario(5'b00000, 0, 0, 0, 0, 0, 5);
    scenarios[4]  = makeScenario(5'b01100, 0, 0, 20, 20, 0, 8); // Long East burst.
    scenarios[5]  = makeScenario(5'b01000, 0, 0, 20, 20, 0, 8); // East drops out.
    scenarios[6]  = makeScenario(5'b00000, 0, 0, 0, 0, 0, 5);
    scenarios[7]  = makeScenario(5'b11111, 4, 0, 4, 0, 4, 30);
    scenarios[8]  = makeScenario(5'b00000, 0, 0, 0, 0, 0, 5);
    scenarios[9]  = makeScenario(5'b11111, 0, 0, 0, 0, 0, 15);  // One-flit bursts.
    scenarios[10] = makeScenario(5'b00000, 0, 0, 0, 0, 0, 5);
    scenarios[11] = makeScenario(5'b00001, 1, 0, 0, 0, 0, 10);  // Lone Local requester.
    scenarios[12] = makeScenario(5'b00000, 0, 0, 0, 0, 0, 6);

    repeat (2) @(posedge clk);
    rst <= 1'b0;
    resetModel();

    for (int i = 0; i < numScenarios; i++)
    begin
      runScenario(i);
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== sim/outputChannel_sva.sv ====
`timescale 1ns/1ns

module outputChannelSva
  import nocPkg::*;
(
  input logic    clk,
  input logic    rst,
  input portVecT grant,
  input outFlitT outFlit
);

  // At most one port owns the output.
  grantOneHot: assert property (
    @(posedge clk) disable iff (rst)
    $onehot0(grant)
  )
  else
    $error("grant is not one-hot or zero: %b", grant);

  grantClearedByReset: assert property (
    @(posedge clk)
    rst |=> (grant == '0)
  )
  else
    $error("grant is not zero after reset: %b", grant);

  srcInRange: assert property (
    @(posedge clk) disable iff (rst)
    outFlit.valid |-> (int'(outFlit.src) < numPorts)
  )
  else
    $error("valid output flit has source %0d", outFlit.src);

endmodule

// Switch stage sees the arbiter grant and the registered output.
bind switchStage outputChannelSva checkInst (
  .clk    (clk),
  .rst    (rst),
  .grant  (grant),
  .outFlit(outFlit)
);

// ==== src/outputChannel.sv ====
`timescale 1ns/1ns

module outputChannel
  import nocPkg::*;
#(
  parameter int TimerWidth = 12
)
(
  input  logic    clk,
  input  logic    rst,
  input  flitT    inFlit [numPorts],
  input  portVecT inReq,
  output outFlitT outFlit
);

  flitT                  decFlit [numPorts];
  portVecT               decReq;
  portVecT               decHeader;
  portVecT               grant;
  logic [TimerWidth-1:0] decLength [numPorts];

  // Header length field sized to the timer.
  for (genvar p = 0; p < numPorts; p++)
  begin : lengthTap
    assign decLength[p] = TimerWidth'(decFlit[p].length);
  end

  flitDecoder decodeStage (
    .clk      (clk),
    .rst      (rst),
    .inFlit   (inFlit),
    .inReq    (inReq),
    .decFlit  (decFlit),
    .decReq   (decReq),
    .decHeader(decHeader)
  );

  outputArbiter #(
    .TimerWidth(TimerWidth)
  ) arbStage (
    .clk    (clk),
    .rst    (rst),
    .req    (decReq),
    .header (decHeader),
    .lengths(decLength),
    .grant  (grant)
  );

  switchStage switchInst (
    .clk    (clk),
    .rst    (rst),
    .grant  (grant),
    .decFlit(decFlit),
    .outFlit(outFlit)
  );

endmodule

// ==== src/switchStage.sv ====
`timescale 1ns/1ns

module switchStage
  import nocPkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  portVecT grant,
  input  flitT    decFlit [numPorts],
  output outFlitT outFlit
);

  portIdxT selIdx;
  outFlitT nextOut;

  // Grant is one-hot, so the encoder needs no priority.
  always_comb
  begin
    selIdx = portLocal;
    for (int p = 0; p < numPorts; p++)
    begin
      if (grant[p])
        selIdx = portIdxT'(p);
    end
  end

  always_comb
  begin
    nextOut = '0; // Idle cycles drive an all-zero flit.
    if (|grant)
    begin
      nextOut.valid = 1'b1;
      nextOut.src   = selIdx;
      nextOut.flit  = decFlit[selIdx];
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      outFlit <= '0;
    else
      outFlit <= nextOut;
  end

endmodule

// ==== src/outputArbiter.sv ====
`timescale 1ns/1ns

module outputArbiter
  import nocPkg::*;
#(
  parameter int TimerWidth = 12
)
(
  input  logic                  clk,
  input  logic                  rst,
  input  portVecT               req,
  input  portVecT               header,
  input  logic [TimerWidth-1:0] lengths [numPorts],
  output portVecT               grant
);

  arbStateT state;
  arbStateT nextState;
  portVecT  run;
  portVecT  timesUp;
  portIdxT  curPort;
  logic     busy;

  function automatic arbStateT stateOf(portIdxT p);
    case (p)
      portLocal: return grantL;
      portNorth: return grantN;
      portEast:  return grantE;
      portWest:  return grantW;
      portSouth: return grantS;
      default:   return idle;
    endcase
  endfunction

  // Scans span ports after last, nearest first in cyclic order.
  function automatic arbStateT pickNext(portVecT reqs, portIdxT last, int span);
    arbStateT pick;
    int       idx;
    pick = idle;
    for (int k = span; k >= 1; k--)
    begin
      idx = (int'(last) + k) % numPorts;
      if (reqs[idx])
        pick = stateOf(portIdxT'(idx)); // Closer ports overwrite farther ones.
    end
    return pick;
  endfunction

  always_comb
  begin
    busy    = 1'b1;
    curPort = portLocal;
    case (state)
      grantL: curPort = portLocal;
      grantN: curPort = portNorth;
      grantE: curPort = portEast;
      grantW: curPort = portWest;
      grantS: curPort = portSouth;
      default:
      begin
        busy = 1'b0; // Idle.
      end
    endcase
  end

  // Holder keeps the output while it requests and its timer has not expired.
  // On release the scan wraps round to the holder last, so a lone requester
  // is granted again at once.
  always_comb
  begin
    nextState = pickNext(req, portSouth, numPorts); // Idle scan starts at Local.
    run       = '0;
    if (busy)
    begin
      if (req[curPort] && !timesUp[curPort])
      begin
        nextState    = state;
        run[curPort] = 1'b1;
      end
      else
      begin
        nextState = pickNext(req, curPort, numPorts);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= idle;
    else
      state <= nextState;
  end

  assign grant = state[numPorts:1];

  for (genvar p = 0; p < numPorts; p++)
  begin : timers
    packetTimer #(
      .TimerWidth(TimerWidth)
    ) timerInst (
      .clk    (clk),
      .rst    (rst),
      .load   (header[p]),
      .length (lengths[p]),
      .run    (run[p]),
      .timesUp(timesUp[p])
    );
  end

endmodule

// ==== src/packetTimer.sv ====
`timescale 1ns/1ns

module packetTimer
#(
  parameter int TimerWidth = 12
)
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  load,
  input  logic [TimerWidth-1:0] length,
  input  logic                  run,
  output logic                  timesUp
);

  logic [TimerWidth-1:0] timeout;
  logic [TimerWidth-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      timeout <= '0;
      count   <= '0;
    end
    else
    begin
      if (load)
        timeout <= length; // Kept until the next header.
      if (run)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  // Count runs 0..timeout, so a burst is timeout plus one cycles.
  assign timesUp = (count == timeout);

endmodule

// ==== src/flitDecoder.sv ====
`timescale 1ns/1ns

module flitDecoder
  import nocPkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  flitT    inFlit [numPorts],
  input  portVecT inReq,
  output flitT    decFlit [numPorts],
  output portVecT decReq,
  output portVecT decHeader
);

  portVecT headerHit;

  // A header only counts when its port is actually requesting.
  always_comb
  begin
    for (int p = 0; p < numPorts; p++)
    begin
      headerHit[p] = inReq[p] && (inFlit[p].flitId == headerId);
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int p = 0; p < numPorts; p++)
      begin
        decFlit[p] <= '0;
      end
      decReq    <= '0;
      decHeader <= '0;
    end
    else
    begin
      for (int p = 0; p < numPorts; p++)
      begin
        decFlit[p] <= inFlit[p];
      end
      decReq    <= inReq;
      decHeader <= headerHit; // Timers load on this flag.
    end
  end

endmodule

// ==== src/nocPkg.sv ====
package nocPkg;

  // Local, North, East, West, South.
  localparam int numPorts = 5;

  typedef logic [2:0] portIdxT;
  typedef logic [numPorts-1:0] portVecT;

  localparam portIdxT portLocal = 3'd0;
  localparam portIdxT portNorth = 3'd1;
  localparam portIdxT portEast  = 3'd2;
  localparam portIdxT portWest  = 3'd3;
  localparam portIdxT portSouth = 3'd4;

  localparam logic [2:0] headerId = 3'd1; // Marks the first flit of a packet.

  typedef struct packed
  {
    logic [2:0]  flitId;
    logic [11:0] length; // Valid in header flits only.
    logic [15:0] data;
  } flitT;

  typedef struct packed
  {
    logic    valid;
    portIdxT src;
    flitT    flit;
  } outFlitT;

  // Bit 0 is idle, bits 1 to 5 follow the port order.
  typedef enum logic [5:0]
  {
    idle   = 6'b000001,
    grantL = 6'b000010,
    grantN = 6'b000100,
    grantE = 6'b001000,
    grantW = 6'b010000,
    grantS = 6'b100000
  } arbStateT;

endpackage
